//--- hdl/mmu_pkg.sv
// flat Sv32 PTE table, 4 KiB pages only, no ASIDs, no megapages, no MXR
`default_nettype none

package mmu_pkg;

  // ----------------------------------------
  // address widths
  // ----------------------------------------
  // sv32 virtual address
  localparam int unsigned VLEN  = 32;
  // sv32 physical address is 34 bits wide
  localparam int unsigned PLEN  = 34;
  localparam int unsigned PPNW  = 22;
  localparam int unsigned VPNW  = 20;
  // offset within a 4 KiB page
  localparam int unsigned PGOFS = 12;

  // privilege levels the mmu checks against
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01
  } priv_t;

  // sv32 page table entry, msb first
  typedef struct packed {
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    logic            d;
    logic            a;
    logic            g;
    logic            u;
    logic            x;
    logic            w;
    logic            r;
    logic            v;
  } pte_t;

  // exception as handed to the core
  typedef struct packed {
    logic            valid;
    logic [3:0]      cause;
    logic [VLEN-1:0] tval;
  } exc_t;

  // ----------------------------------------
  // mcause codes
  // ----------------------------------------
  localparam logic [3:0] CAUSE_INSTR_ACCESS = 4'd1;
  localparam logic [3:0] CAUSE_LD_ACCESS    = 4'd5;
  localparam logic [3:0] CAUSE_ST_ACCESS    = 4'd7;
  localparam logic [3:0] CAUSE_INSTR_PAGE   = 4'd12;
  localparam logic [3:0] CAUSE_LD_PAGE      = 4'd13;
  localparam logic [3:0] CAUSE_ST_PAGE      = 4'd15;

  // refill result, returned only to the path that missed
  typedef struct packed {
    logic            valid;
    logic            page_fault;
    logic            access_fault;
    logic [VPNW-1:0] vpn;
    pte_t            pte;
  } refill_t;

  // miss request from one translation path
  typedef struct packed {
    logic            valid;
    logic [VPNW-1:0] vpn;
  } miss_t;

  // ----------------------------------------
  // axi4-lite read channels
  // ----------------------------------------
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // master to slave, arready travels back as its own port
  typedef struct packed {
    logic            arvalid;
    logic [PLEN-1:0] araddr;
    logic [1:0]      arprot;
  } axil_ar_t;

  // slave to master, rready travels back as its own port
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_r_t;

endpackage

`default_nettype wire

//--- hdl/tlb.sv
// fully associative, lookup is combinational; a refill must not hit an entry already present
`timescale 1ns/1ns
`default_nettype none

module tlb import mmu_pkg::*; #(
  parameter int unsigned ENTRIES = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            flush_i,
  input  logic [VPNW-1:0] lu_vpn_i,
  output logic            lu_hit_o,
  output pte_t            lu_pte_o,
  input  refill_t         wr_i
);

  // victim pointer width, at least one bit
  localparam int unsigned IDXW = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  // tag and pte storage
  logic [VPNW-1:0]    tag_q [ENTRIES];
  pte_t               pte_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] hit_vec;
  logic [IDXW-1:0]    victim_q;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  // all tags compared in parallel
  always_comb begin
    lu_pte_o = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      hit_vec[i] = valid_q[i] && (tag_q[i] == lu_vpn_i);
      // at most one entry matches, so the last match is the only one
      if (hit_vec[i]) begin
        lu_pte_o = pte_q[i];
      end
    end
  end

  assign lu_hit_o = |hit_vec;

  // ----------------------------------------
  // write and flush
  // ----------------------------------------
  // flush clears every entry and beats a write in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_i.valid) begin
      valid_q[victim_q] <= 1'b1;
      // round robin over the entries
      if (victim_q == IDXW'(ENTRIES - 1)) begin
        victim_q <= '0;
      end else begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  // tag and pte follow the victim pointer
  always_ff @(posedge clk_i) begin
    if (wr_i.valid && !flush_i) begin
      tag_q[victim_q] <= wr_i.vpn;
      pte_q[victim_q] <= wr_i.pte;
    end
  end

  // a double hit would mean the refill unit served a page this tlb already held
  a_single_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(hit_vec))
    else $error("tlb: more than one entry hits vpn %h", lu_vpn_i);

endmodule

`default_nettype wire

//--- hdl/itlb_translate.sv
// answers in the request cycle on a hit; requester holds fetch_req_i and address until valid
`timescale 1ns/1ns
`default_nettype none

module itlb_translate import mmu_pkg::*; #(
  parameter int unsigned ENTRIES = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            enable_i,
  input  logic            flush_tlb_i,
  input  logic            fetch_req_i,
  input  logic [VLEN-1:0] fetch_vaddr_i,
  input  priv_t           priv_lvl_i,
  output logic            fetch_valid_o,
  output logic [PLEN-1:0] fetch_paddr_o,
  output exc_t            fetch_exc_o,
  output miss_t           miss_o,
  input  refill_t         refill_i
);

  logic    tlb_hit;
  pte_t    tlb_pte;
  refill_t tlb_wr;
  logic    refill_fault;
  logic    perm_err;

  assign refill_fault = refill_i.page_fault || refill_i.access_fault;

  // only a clean refill is written into the itlb
  always_comb begin
    tlb_wr       = refill_i;
    tlb_wr.valid = refill_i.valid && !refill_fault;
  end

  tlb #(
    .ENTRIES (ENTRIES)
  ) i_itlb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_tlb_i),
    .lu_vpn_i (fetch_vaddr_i[VLEN-1:PGOFS]),
    .lu_hit_o (tlb_hit),
    .lu_pte_o (tlb_pte),
    .wr_i     (tlb_wr)
  );

  // page must be executable, user pages for U mode only
  assign perm_err = !tlb_pte.x
                 || ((priv_lvl_i == PRIV_U) && !tlb_pte.u)
                 || ((priv_lvl_i == PRIV_S) && tlb_pte.u);

  // miss stays up until the refill for this fetch comes back
  assign miss_o.valid = fetch_req_i && enable_i && !tlb_hit && !refill_i.valid;
  assign miss_o.vpn   = fetch_vaddr_i[VLEN-1:PGOFS];

  // ----------------------------------------
  // fetch response
  // ----------------------------------------
  always_comb begin
    // translation off, pass the address through
    fetch_valid_o    = fetch_req_i;
    fetch_paddr_o    = {{(PLEN-VLEN){1'b0}}, fetch_vaddr_i};
    fetch_exc_o      = '0;
    fetch_exc_o.tval = fetch_vaddr_i;
    if (enable_i) begin
      fetch_valid_o = 1'b0;
      fetch_paddr_o = {tlb_pte.ppn, fetch_vaddr_i[PGOFS-1:0]};
      if (tlb_hit) begin
        // hit answers in the same cycle
        fetch_valid_o = fetch_req_i;
        if (perm_err) begin
          fetch_exc_o.valid = fetch_req_i;
          fetch_exc_o.cause = CAUSE_INSTR_PAGE;
        end
      end else if (refill_i.valid && refill_fault) begin
        // faulting refill completes the held fetch right away
        fetch_valid_o     = fetch_req_i;
        fetch_exc_o.valid = fetch_req_i;
        fetch_exc_o.cause = refill_i.page_fault ? CAUSE_INSTR_PAGE : CAUSE_INSTR_ACCESS;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/dtlb_translate.sv
// answers one cycle after the lookup; requester holds lsu_req_i and its inputs until valid
`timescale 1ns/1ns
`default_nettype none

module dtlb_translate import mmu_pkg::*; #(
  parameter int unsigned ENTRIES = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            enable_i,
  input  logic            flush_tlb_i,
  input  logic            lsu_req_i,
  input  logic [VLEN-1:0] lsu_vaddr_i,
  input  logic            lsu_is_store_i,
  input  priv_t           ld_st_priv_lvl_i,
  input  logic            sum_i,
  output logic            lsu_valid_o,
  output logic [PLEN-1:0] lsu_paddr_o,
  output exc_t            lsu_exc_o,
  output miss_t           miss_o,
  input  refill_t         refill_i
);

  // registered request and lookup result
  logic            req_q;
  logic            hit_q;
  logic [VLEN-1:0] vaddr_q;
  logic            is_store_q;
  priv_t           priv_q;
  logic            sum_q;
  pte_t            pte_q;
  // lookup sampled during the refill cycle is stale
  logic            refill_wait_q;

  logic    tlb_hit;
  pte_t    tlb_pte;
  refill_t tlb_wr;
  logic    refill_fault;
  logic    access_err;

  assign refill_fault = refill_i.page_fault || refill_i.access_fault;

  always_comb begin
    tlb_wr       = refill_i;
    tlb_wr.valid = refill_i.valid && !refill_fault;
  end

  tlb #(
    .ENTRIES (ENTRIES)
  ) i_dtlb (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_tlb_i),
    .lu_vpn_i (lsu_vaddr_i[VLEN-1:PGOFS]),
    .lu_hit_o (tlb_hit),
    .lu_pte_o (tlb_pte),
    .wr_i     (tlb_wr)
  );

  // ----------------------------------------
  // request stage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q         <= 1'b0;
      hit_q         <= 1'b0;
      refill_wait_q <= 1'b0;
    end else begin
      // a request completing now is still on the inputs and must not be taken twice
      req_q         <= lsu_req_i && !lsu_valid_o;
      hit_q         <= tlb_hit;
      refill_wait_q <= refill_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q    <= lsu_vaddr_i;
    is_store_q <= lsu_is_store_i;
    priv_q     <= ld_st_priv_lvl_i;
    sum_q      <= sum_i;
    pte_q      <= tlb_pte;
  end

  // S mode reaches user pages only with SUM and U mode reaches only user pages
  assign access_err = ((priv_q == PRIV_S) && !sum_q && pte_q.u)
                   || ((priv_q == PRIV_U) && !pte_q.u);

  assign miss_o.valid = req_q && enable_i && !hit_q && !refill_wait_q;
  assign miss_o.vpn   = vaddr_q[VLEN-1:PGOFS];

  // ----------------------------------------
  // load and store response
  // ----------------------------------------
  always_comb begin
    lsu_valid_o    = req_q;
    lsu_paddr_o    = {{(PLEN-VLEN){1'b0}}, vaddr_q};
    lsu_exc_o      = '0;
    lsu_exc_o.tval = vaddr_q;
    if (enable_i) begin
      lsu_valid_o = 1'b0;
      lsu_paddr_o = {pte_q.ppn, vaddr_q[PGOFS-1:0]};
      if (req_q && hit_q) begin
        lsu_valid_o = 1'b1;
        if (is_store_q) begin
          // stores need a writable page that is already dirty
          if (!pte_q.w || !pte_q.d || access_err) begin
            lsu_exc_o.valid = 1'b1;
            lsu_exc_o.cause = CAUSE_ST_PAGE;
          end
        end else if (!pte_q.r || access_err) begin
          lsu_exc_o.valid = 1'b1;
          lsu_exc_o.cause = CAUSE_LD_PAGE;
        end
      end else if (req_q && refill_i.valid && refill_fault) begin
        // refill fault ends the request in this cycle
        lsu_valid_o     = 1'b1;
        lsu_exc_o.valid = 1'b1;
        if (refill_i.page_fault) begin
          lsu_exc_o.cause = is_store_q ? CAUSE_ST_PAGE : CAUSE_LD_PAGE;
        end else begin
          lsu_exc_o.cause = is_store_q ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
        end
      end
    end
  end

  // a completion belongs to the registered request that is still held on the inputs
  a_valid_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lsu_valid_o |-> (lsu_req_i && (lsu_vaddr_i == vaddr_q)))
    else $error("dtlb: lsu_valid_o without a registered request");

endmodule

`default_nettype wire

//--- hdl/pte_refill.sv
// one AXI4-Lite read in flight; satp_ppn_i is sampled when a miss is taken
`timescale 1ns/1ns
`default_nettype none

module pte_refill import mmu_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic [PPNW-1:0] satp_ppn_i,
  input  miss_t           imiss_i,
  input  miss_t           dmiss_i,
  output refill_t         irefill_o,
  output refill_t         drefill_o,
  output logic            itlb_miss_o,
  output logic            dtlb_miss_o,
  output axil_ar_t        ar_o,
  input  logic            arready_i,
  input  axil_r_t         r_i,
  output logic            rready_o
);

  // secure privileged data access
  localparam logic [1:0] ARPROT_DATA_PRIV = 2'b01;

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_DATA
  } state_e;

  state_e          state_q, state_d;
  // high while the instruction path is served
  logic            serve_instr_q, serve_instr_d;
  logic [VPNW-1:0] vpn_q, vpn_d;
  logic [PLEN-1:0] araddr_q, araddr_d;

  miss_t   sel_miss;
  logic    ar_hs;
  logic    r_hs;
  pte_t    rd_pte;
  logic    rd_access_err;
  logic    rd_page_err;
  refill_t refill;

  // fetch misses win over data misses
  assign sel_miss = imiss_i.valid ? imiss_i : dmiss_i;

  // ----------------------------------------
  // fsm
  // ----------------------------------------
  always_comb begin
    state_d       = state_q;
    serve_instr_d = serve_instr_q;
    vpn_d         = vpn_q;
    araddr_d      = araddr_q;
    unique case (state_q)
      S_IDLE: begin
        if (sel_miss.valid) begin
          state_d       = S_ADDR;
          serve_instr_d = imiss_i.valid;
          vpn_d         = sel_miss.vpn;
          // flat table with one word per vpn above satp
          araddr_d      = {satp_ppn_i, {PGOFS{1'b0}}} + PLEN'({sel_miss.vpn, 2'b00});
        end
      end
      S_ADDR: begin
        if (ar_hs) begin
          state_d = S_DATA;
        end
      end
      S_DATA: begin
        if (r_hs) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= S_IDLE;
      serve_instr_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      serve_instr_q <= serve_instr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    vpn_q    <= vpn_d;
    araddr_q <= araddr_d;
  end

  // ----------------------------------------
  // axi4-lite read
  // ----------------------------------------
  assign ar_o.arvalid = (state_q == S_ADDR);
  assign ar_o.araddr  = araddr_q;
  assign ar_o.arprot  = ARPROT_DATA_PRIV;
  assign rready_o     = (state_q == S_DATA);

  assign ar_hs = ar_o.arvalid && arready_i;
  assign r_hs  = r_i.rvalid && rready_o;

  // one miss pulse per AR handshake for the path it was made for
  assign itlb_miss_o = ar_hs && serve_instr_q;
  assign dtlb_miss_o = ar_hs && !serve_instr_q;

  // ----------------------------------------
  // pte classification
  // ----------------------------------------
  assign rd_pte        = r_i.rdata;
  // any response but OKAY is an access fault
  assign rd_access_err = (r_i.rresp != AXI_RESP_OKAY);
  // no valid leaf or the reserved write-only encoding
  assign rd_page_err   = !rd_access_err
                      && (!rd_pte.v || !rd_pte.r || (rd_pte.w && !rd_pte.r));

  always_comb begin
    refill.valid        = r_hs;
    refill.page_fault   = rd_page_err;
    refill.access_fault = rd_access_err;
    refill.vpn          = vpn_q;
    refill.pte          = rd_pte;
    // result goes only to the path being served
    irefill_o           = refill;
    irefill_o.valid     = r_hs && serve_instr_q;
    drefill_o           = refill;
    drefill_o.valid     = r_hs && !serve_instr_q;
  end

  a_araddr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ar_o.arvalid && !arready_i) |=> (ar_o.arvalid && $stable(ar_o.araddr)))
    else $error("pte_refill: araddr changed while waiting for arready");

  // no AR may overlap the read in flight that rready marks
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rready_o |-> !ar_o.arvalid)
    else $error("pte_refill: second AR before the R handshake");

endmodule

`default_nettype wire

//--- hdl/mmu_sv32.sv
// Sv32 mmu with flat PTE table; fetch and load/store translate in parallel, one shared refill
`timescale 1ns/1ns
`default_nettype none

module mmu_sv32 import mmu_pkg::*; #(
  parameter int unsigned ITLB_ENTRIES = 4,
  parameter int unsigned DTLB_ENTRIES = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // csr state
  input  logic            enable_translation_i,
  input  logic            en_ld_st_translation_i,
  input  logic            flush_tlb_i,
  input  logic [PPNW-1:0] satp_ppn_i,
  // instruction fetch
  input  logic            fetch_req_i,
  input  logic [VLEN-1:0] fetch_vaddr_i,
  input  priv_t           priv_lvl_i,
  output logic            fetch_valid_o,
  output logic [PLEN-1:0] fetch_paddr_o,
  output exc_t            fetch_exc_o,
  // load and store unit
  input  logic            lsu_req_i,
  input  logic [VLEN-1:0] lsu_vaddr_i,
  input  logic            lsu_is_store_i,
  input  priv_t           ld_st_priv_lvl_i,
  input  logic            sum_i,
  output logic            lsu_valid_o,
  output logic [PLEN-1:0] lsu_paddr_o,
  output exc_t            lsu_exc_o,
  // miss pulses for the performance counters
  output logic            itlb_miss_o,
  output logic            dtlb_miss_o,
  // pte fetch over axi4-lite read
  output axil_ar_t        ar_o,
  input  logic            arready_i,
  input  axil_r_t         r_i,
  output logic            rready_o
);

  miss_t   imiss;
  miss_t   dmiss;
  refill_t irefill;
  refill_t drefill;

  // ----------------------------------------
  // instruction path
  // ----------------------------------------
  itlb_translate #(
    .ENTRIES (ITLB_ENTRIES)
  ) i_itlb_translate (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .enable_i      (enable_translation_i),
    .flush_tlb_i   (flush_tlb_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_vaddr_i (fetch_vaddr_i),
    .priv_lvl_i    (priv_lvl_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_paddr_o (fetch_paddr_o),
    .fetch_exc_o   (fetch_exc_o),
    .miss_o        (imiss),
    .refill_i      (irefill)
  );

  // ----------------------------------------
  // data path
  // ----------------------------------------
  dtlb_translate #(
    .ENTRIES (DTLB_ENTRIES)
  ) i_dtlb_translate (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .enable_i         (en_ld_st_translation_i),
    .flush_tlb_i      (flush_tlb_i),
    .lsu_req_i        (lsu_req_i),
    .lsu_vaddr_i      (lsu_vaddr_i),
    .lsu_is_store_i   (lsu_is_store_i),
    .ld_st_priv_lvl_i (ld_st_priv_lvl_i),
    .sum_i            (sum_i),
    .lsu_valid_o      (lsu_valid_o),
    .lsu_paddr_o      (lsu_paddr_o),
    .lsu_exc_o        (lsu_exc_o),
    .miss_o           (dmiss),
    .refill_i         (drefill)
  );

  // shared refill, serves one miss at a time
  pte_refill i_pte_refill (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .satp_ppn_i  (satp_ppn_i),
    .imiss_i     (imiss),
    .dmiss_i     (dmiss),
    .irefill_o   (irefill),
    .drefill_o   (drefill),
    .itlb_miss_o (itlb_miss_o),
    .dtlb_miss_o (dtlb_miss_o),
    .ar_o        (ar_o),
    .arready_i   (arready_i),
    .r_i         (r_i),
    .rready_o    (rready_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_mmu_sv32.sv
// PTE memory is flat at SATP_PPN, answers SLVERR for vpn f0000 and up; requests are held until valid
`timescale 1ns/1ns
`default_nettype none

module tb_mmu_sv32 import mmu_pkg::*; ();

  // ----------------------------------------
  // run constants
  // ----------------------------------------
  localparam logic [31:0]     SEED      = 32'h7d8d59cb;
  localparam logic [PPNW-1:0] SATP_PPN  = 22'h12a5c1;
  localparam logic [PLEN-1:0] SATP_BASE = {SATP_PPN, 12'h000};
  // privileged data read on the AR channel
  localparam logic [1:0]      PROT_DATA_PRIV = 2'b01;
  localparam int N_OFF  = 8;
  localparam int N_RAND = 32;
  localparam int N_MIX  = 32;
  // the directed fault and reuse tests add 12 requests
  localparam int N_REQ      = 2 * N_OFF + 2 * N_RAND + 12 + 2 * N_MIX;
  localparam int MAX_CYCLES = 200 * N_REQ + 10;

  // expected translation of one request
  typedef struct packed {
    logic [PLEN-1:0] paddr;
    exc_t            exc;
  } xlat_t;

  logic clk_i, arst_n_i;
  logic enable_translation_i, en_ld_st_translation_i, flush_tlb_i;
  logic [PPNW-1:0] satp_ppn_i;
  logic fetch_req_i, fetch_valid_o;
  logic [VLEN-1:0] fetch_vaddr_i;
  priv_t priv_lvl_i;
  logic [PLEN-1:0] fetch_paddr_o;
  exc_t fetch_exc_o;
  logic lsu_req_i, lsu_is_store_i, sum_i, lsu_valid_o;
  logic [VLEN-1:0] lsu_vaddr_i;
  priv_t ld_st_priv_lvl_i;
  logic [PLEN-1:0] lsu_paddr_o;
  exc_t lsu_exc_o;
  logic itlb_miss_o, dtlb_miss_o;
  axil_ar_t ar_o;
  logic arready_i, rready_o;
  axil_r_t r_i;

  // handshake, miss and timeout counters
  int ar_cnt, imiss_cnt, dmiss_cnt;
  int cycles = 0;
  int err_cnt = 0;
  string test_name;
  // separate generators so parallel drivers do not share a sequence
  logic [31:0] fetch_rng, lsu_rng, mem_rng;

  mmu_sv32 #(
    .ITLB_ENTRIES (4),
    .DTLB_ENTRIES (4)
  ) i_mmu_sv32 (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .enable_translation_i (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .flush_tlb_i (flush_tlb_i), .satp_ppn_i (satp_ppn_i),
    .fetch_req_i (fetch_req_i), .fetch_vaddr_i (fetch_vaddr_i), .priv_lvl_i (priv_lvl_i),
    .fetch_valid_o (fetch_valid_o), .fetch_paddr_o (fetch_paddr_o), .fetch_exc_o (fetch_exc_o),
    .lsu_req_i (lsu_req_i), .lsu_vaddr_i (lsu_vaddr_i), .lsu_is_store_i (lsu_is_store_i),
    .ld_st_priv_lvl_i (ld_st_priv_lvl_i), .sum_i (sum_i),
    .lsu_valid_o (lsu_valid_o), .lsu_paddr_o (lsu_paddr_o), .lsu_exc_o (lsu_exc_o),
    .itlb_miss_o (itlb_miss_o), .dtlb_miss_o (dtlb_miss_o),
    .ar_o (ar_o), .arready_i (arready_i), .r_i (r_i), .rready_o (rready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // helpers and reference model
  // ----------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // one of 32 test pages with an eighth of them in the SLVERR range
  function automatic logic [VLEN-1:0] pick_vaddr(input logic [31:0] r);
    return {(r[31:29] == 3'd0) ? 4'hf : 4'h3, 12'h0a5, r[27:24], r[23:12]};
  endfunction

  // PTE contents hashed from the whole vpn
  function automatic pte_t pte_of(input logic [VPNW-1:0] vpn);
    logic [31:0] h;
    pte_t        p;
    h     = {12'h000, vpn} * 32'h9e3779b1;
    p     = '0;
    p.ppn = {2'b10, vpn ^ h[31:12]};
    // roughly one PTE in eight is not valid
    p.v   = (h[31:29] != 3'd0);
    p.r   = h[24] | h[25];
    p.w   = h[26];
    p.x   = h[27];
    p.u   = h[28];
    p.d   = h[23];
    p.a   = 1'b1;
    return p;
  endfunction

  function automatic logic slverr_of(input logic [VPNW-1:0] vpn);
    return (vpn[19:16] == 4'hf);
  endfunction

  // first page with a good leaf or first page with v clear
  function automatic logic [VPNW-1:0] find_vpn(input logic want_leaf);
    logic [VPNW-1:0] vpn;
    pte_t            p;
    vpn = '0;
    for (int i = 0; i < 256; i++) begin
      vpn = {4'h3, 8'h0a, 8'(i)};
      p   = pte_of(vpn);
      if (want_leaf ? (p.v && p.r) : !p.v) begin
        return vpn;
      end
    end
    return vpn;
  endfunction

  function automatic xlat_t ref_xlat(input logic [VLEN-1:0] va, input logic fetch,
                                     input logic store, input priv_t priv, input logic sum,
                                     input logic en, input pte_t pte, input logic slverr);
    xlat_t x;
    logic  pf;
    x.paddr     = {2'b00, va};
    x.exc.valid = 1'b0;
    x.exc.cause = 4'd0;
    x.exc.tval  = va;
    if (en) begin
      x.paddr = {pte.ppn, va[PGOFS-1:0]};
      // no valid leaf or the write-only encoding
      pf = !pte.v || !pte.r || (pte.w && !pte.r);
      if (fetch) begin
        pf = pf || !pte.x || ((priv == PRIV_U) && !pte.u) || ((priv == PRIV_S) && pte.u);
      end else begin
        pf = pf || (store && (!pte.w || !pte.d));
        pf = pf || ((priv == PRIV_S) && !sum && pte.u) || ((priv == PRIV_U) && !pte.u);
      end
      if (slverr) begin
        x.exc.valid = 1'b1;
        x.exc.cause = fetch ? CAUSE_INSTR_ACCESS : (store ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS);
      end else if (pf) begin
        x.exc.valid = 1'b1;
        x.exc.cause = fetch ? CAUSE_INSTR_PAGE : (store ? CAUSE_ST_PAGE : CAUSE_LD_PAGE);
      end
    end
    return x;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] want, input logic [63:0] got);
    if (want !== got) begin
      err_cnt++;
      $display("Fail %s: expected %0h, actual %0h", name, want, got);
      $display("Checks failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // paddr only matters without an exception and cause and tval only with one
  task automatic compare_result(input string path, input xlat_t want,
                                input logic [PLEN-1:0] paddr, input exc_t exc);
    check_eq({test_name, " ", path, " exc valid"}, 64'(want.exc.valid), 64'(exc.valid));
    if (want.exc.valid) begin
      check_eq({test_name, " ", path, " cause"}, 64'(want.exc.cause), 64'(exc.cause));
      check_eq({test_name, " ", path, " tval"}, 64'(want.exc.tval), 64'(exc.tval));
    end else begin
      check_eq({test_name, " ", path, " paddr"}, 64'(want.paddr), 64'(paddr));
    end
  endtask

  // ----------------------------------------
  // drivers entered and left 1 ns after a rising edge
  // ----------------------------------------
  task automatic run_fetch(input logic [VLEN-1:0] va, input priv_t priv);
    fetch_req_i   = 1'b1;
    fetch_vaddr_i = va;
    priv_lvl_i    = priv;
    @(negedge clk_i);
    while (!fetch_valid_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    fetch_req_i = 1'b0;
  endtask

  task automatic run_lsu(input logic [VLEN-1:0] va, input logic store, input priv_t priv,
                         input logic sum);
    lsu_req_i        = 1'b1;
    lsu_vaddr_i      = va;
    lsu_is_store_i   = store;
    ld_st_priv_lvl_i = priv;
    sum_i            = sum;
    @(negedge clk_i);
    while (!lsu_valid_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    lsu_req_i = 1'b0;
  endtask

  task automatic pulse_flush();
    flush_tlb_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_tlb_i = 1'b0;
  endtask

  // one access and then the number of new AR handshakes and miss pulses it caused
  task automatic access_counted(input logic fetch, input logic [VLEN-1:0] va, input int new_ar);
    int ar0, im0, dm0;
    ar0 = ar_cnt;
    im0 = imiss_cnt;
    dm0 = dmiss_cnt;
    if (fetch) run_fetch(va, PRIV_S);
    else run_lsu(va, 1'b0, PRIV_S, 1'b1);
    check_eq({test_name, " AR handshakes"}, 64'(new_ar), 64'(ar_cnt - ar0));
    check_eq({test_name, " itlb miss pulses"}, 64'(fetch ? new_ar : 0), 64'(imiss_cnt - im0));
    check_eq({test_name, " dtlb miss pulses"}, 64'(fetch ? 0 : new_ar), 64'(dmiss_cnt - dm0));
  endtask

  // ----------------------------------------
  // AXI4-Lite PTE memory with random delays
  // ----------------------------------------
  initial begin : pte_memory
    logic [VPNW-1:0] rd_vpn;
    arready_i = 1'b0;
    r_i       = '0;
    mem_rng   = SEED ^ 32'haaaaaaaa;
    forever begin
      @(posedge clk_i);
      #1;
      if (ar_o.arvalid) begin
        mem_rng = lcg_step(mem_rng);
        repeat (mem_rng[31:30]) begin
          @(posedge clk_i);
          #1;
        end
        // the AR waits for arready and no read is in flight yet
        check_eq({test_name, " axi arvalid held"}, 64'(1), 64'(ar_o.arvalid));
        check_eq({test_name, " axi rready before AR"}, 64'(0), 64'(rready_o));
        check_eq({test_name, " axi arprot"}, 64'(PROT_DATA_PRIV), 64'(ar_o.arprot));
        arready_i = 1'b1;
        rd_vpn    = VPNW'((ar_o.araddr - SATP_BASE) >> 2);
        check_eq({test_name, " axi araddr alignment"}, 64'(0), 64'(ar_o.araddr[1:0]));
        @(posedge clk_i);
        #1;
        arready_i = 1'b0;
        repeat (mem_rng[29:28]) begin
          @(posedge clk_i);
          #1;
        end
        // rready stays up from the AR handshake on
        check_eq({test_name, " axi rready after AR"}, 64'(1), 64'(rready_o));
        r_i.rvalid = 1'b1;
        r_i.rdata  = pte_of(rd_vpn);
        // SLVERR for the marked range
        r_i.rresp  = slverr_of(rd_vpn) ? 2'b10 : 2'b00;
        @(posedge clk_i);
        #1;
        r_i = '0;
        check_eq({test_name, " axi rready after R"}, 64'(0), 64'(rready_o));
      end
    end
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_cnt    <= 0;
      imiss_cnt <= 0;
      dmiss_cnt <= 0;
    end else begin
      if (ar_o.arvalid && arready_i) ar_cnt <= ar_cnt + 1;
      if (itlb_miss_o) imiss_cnt <= imiss_cnt + 1;
      if (dtlb_miss_o) dmiss_cnt <= dmiss_cnt + 1;
    end
  end

  // completions are sampled mid cycle while inputs are still held
  always @(negedge clk_i) begin : result_check
    xlat_t want;
    if (arst_n_i && fetch_valid_o) begin
      want = ref_xlat(fetch_vaddr_i, 1'b1, 1'b0, priv_lvl_i, 1'b0, enable_translation_i,
                      pte_of(fetch_vaddr_i[VLEN-1:PGOFS]), slverr_of(fetch_vaddr_i[VLEN-1:PGOFS]));
      compare_result("fetch", want, fetch_paddr_o, fetch_exc_o);
    end
    if (arst_n_i && lsu_valid_o) begin
      want = ref_xlat(lsu_vaddr_i, 1'b0, lsu_is_store_i, ld_st_priv_lvl_i, sum_i,
                      en_ld_st_translation_i, pte_of(lsu_vaddr_i[VLEN-1:PGOFS]),
                      slverr_of(lsu_vaddr_i[VLEN-1:PGOFS]));
      compare_result("lsu", want, lsu_paddr_o, lsu_exc_o);
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : stimulus
    logic [VLEN-1:0] va;
    arst_n_i = 1'b0;
    enable_translation_i = 1'b0;
    en_ld_st_translation_i = 1'b0;
    flush_tlb_i = 1'b0;
    satp_ppn_i = SATP_PPN;
    fetch_req_i = 1'b0;
    fetch_vaddr_i = '0;
    priv_lvl_i = PRIV_S;
    lsu_req_i = 1'b0;
    lsu_vaddr_i = '0;
    lsu_is_store_i = 1'b0;
    ld_st_priv_lvl_i = PRIV_S;
    sum_i = 1'b0;
    fetch_rng = SEED;
    lsu_rng = SEED ^ 32'h55555555;
    test_name = "translation off";
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(posedge clk_i);
    #1;
    // pass-through on both paths leaves memory untouched
    for (int i = 0; i < N_OFF; i++) begin
      fetch_rng = lcg_step(fetch_rng);
      run_fetch(fetch_rng, fetch_rng[11] ? PRIV_S : PRIV_U);
      lsu_rng = lcg_step(lsu_rng);
      run_lsu(lsu_rng, lsu_rng[11], lsu_rng[10] ? PRIV_S : PRIV_U, lsu_rng[9]);
    end
    check_eq("translation off AR handshakes", 64'(0), 64'(ar_cnt));
    test_name = "fetch translate";
    enable_translation_i = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      fetch_rng = lcg_step(fetch_rng);
      run_fetch(pick_vaddr(fetch_rng), fetch_rng[11] ? PRIV_S : PRIV_U);
    end
    test_name = "load store translate";
    en_ld_st_translation_i = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      lsu_rng = lcg_step(lsu_rng);
      run_lsu(pick_vaddr(lsu_rng), lsu_rng[11], lsu_rng[10] ? PRIV_S : PRIV_U, lsu_rng[9]);
    end
    // v clear and then SLVERR on both paths
    test_name = "fault pages";
    va = {find_vpn(1'b0), 12'h124};
    run_fetch(va, PRIV_S);
    run_lsu(va, 1'b0, PRIV_S, 1'b1);
    run_lsu(va, 1'b1, PRIV_U, 1'b0);
    va = {20'hf0a51, 12'h0c8};
    run_fetch(va, PRIV_U);
    run_lsu(va, 1'b0, PRIV_U, 1'b0);
    run_lsu(va, 1'b1, PRIV_S, 1'b1);
    test_name = "tlb reuse and flush";
    va = {find_vpn(1'b1), 12'h3fc};
    pulse_flush();
    access_counted(1'b1, va, 1);
    access_counted(1'b1, va, 0);
    access_counted(1'b0, va, 1);
    access_counted(1'b0, va, 0);
    pulse_flush();
    access_counted(1'b1, va, 1);
    access_counted(1'b0, va, 1);
    test_name = "mixed traffic";
    fork
      begin
        for (int i = 0; i < N_MIX; i++) begin
          fetch_rng = lcg_step(fetch_rng);
          run_fetch(pick_vaddr(fetch_rng), fetch_rng[11] ? PRIV_S : PRIV_U);
        end
      end
      begin
        for (int i = 0; i < N_MIX; i++) begin
          lsu_rng = lcg_step(lsu_rng);
          run_lsu(pick_vaddr(lsu_rng), lsu_rng[11], lsu_rng[10] ? PRIV_S : PRIV_U, lsu_rng[9]);
        end
      end
    join
    if (err_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1, "mismatches found");
    end
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/mmu_pkg.sv
hdl/tlb.sv
hdl/itlb_translate.sv
hdl/dtlb_translate.sv
hdl/pte_refill.sv
hdl/mmu_sv32.sv
tests/tb_mmu_sv32.sv

//--- Makefile
# Verilator build and run for the Sv32 MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu_sv32
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# build, run, and pass only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
